// ==== list.f ====
+incdir+.
bp_pkg.sv
bp_wr_if.sv
bp_cmd_decode.sv
bp_bit_fifo.sv
bp_byte_emit.sv
bp_top.sv
bp_asserts.sv
tb_bp_top.sv

// ==== Makefile ====
TOP = tb_bp_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== tb_bp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module tb_bp_top import bp_pkg::*; ();

   localparam int DATA_W    = `BP_DATA_W;
   localparam int WIDTH_W   = `BP_WIDTH_W;
   localparam int BYTE_W    = `BP_BYTE_W;
   localparam int TIMEOUT   = 2000;
   localparam int CR_MANUAL = 0;
   localparam int CR_AUTO   = 1;
   localparam int CR_RANDOM = 2;

   logic               clk;
   logic               arst_n;
   logic               cmd_valid;
   bp_op_e             cmd_op;
   logic [WIDTH_W-1:0] cmd_width;
   logic [DATA_W-1:0]  cmd_data;
   logic               cmd_credit;
   logic               byte_valid;
   bp_byte_t           byte_data;
   logic               byte_credit;

   // expected bit stream, oldest bit first
   bit       model_q[$];
   // every byte seen on the output, read back in order
   bp_byte_t rx_buf[$];
   int       rx_read      = 0;
   int       cmd_sent     = 0;
   int       cmd_returned = 0;
   int       cr_given     = 0;
   int       cr_requested = 0;
   int       credit_mode  = CR_AUTO;

   bp_top u_dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .cmd_valid_i  (cmd_valid),
      .cmd_op_i     (cmd_op),
      .cmd_width_i  (cmd_width),
      .cmd_data_i   (cmd_data),
      .cmd_credit_o (cmd_credit),
      .byte_valid_o (byte_valid),
      .byte_data_o  (byte_data),
      .byte_credit_i(byte_credit)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("ERROR at %0t: %s", $time, what);
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input bp_byte_t act, input bp_byte_t exp);
      if (act !== exp) begin
         abort_run($sformatf("byte_data_o = 0x%02h, expected 0x%02h", act, exp));
      end
   endtask

   task automatic check_count(input string name, input int act, input int exp);
      if (act != exp) begin
         abort_run($sformatf("%s = %0d, expected %0d", name, act, exp));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // outputs sampled on the falling edge, half a cycle after they change
   always @(negedge clk) begin
      if (arst_n && byte_valid) begin
         rx_buf.push_back(byte_data);
      end
      if (arst_n && cmd_credit) begin
         cmd_returned++;
         if (cmd_returned > cmd_sent) begin
            abort_run("command credit came back for a command never sent");
         end
      end
   end

   // consumer side, frees one slot per received byte
   initial begin : credit_driver
      bit fire;
      byte_credit = 1'b0;
      forever begin
         next_cycle();
         fire = 1'b0;
         if (arst_n && (rx_buf.size() > cr_given)) begin
            case (credit_mode)
               CR_AUTO:   fire = 1'b1;
               CR_RANDOM: fire = ($urandom_range(1, 0) == 1);
               default:   fire = (cr_given < cr_requested);
            endcase
         end
         if (fire) begin
            cr_given++;
         end
         byte_credit = fire;
      end
   end

   task automatic give_credits(input int n);
      int waited;
      waited = 0;
      cr_requested = cr_given + n;
      while (cr_given < cr_requested) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("byte credits could not be handed back");
         end
      end
   endtask

   task automatic send_cmd(input bp_op_e op, input int width, input logic [DATA_W-1:0] data);
      int waited;
      int i;
      waited = 0;
      while (`BP_CMD_DEPTH + cmd_returned - cmd_sent <= 0) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("no command credit came back");
         end
      end
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_width = WIDTH_W'(width);
      cmd_data  = data;
      cmd_sent++;
      if (op == OP_PUSH) begin
         for (i = 0; i < width; i++) begin
            model_q.push_back(data[DATA_W-1-i]);
         end
      end else begin
         while (model_q.size() % BYTE_W != 0) begin
            model_q.push_back(1'b0);
         end
      end
      next_cycle();
      cmd_valid = 1'b0;
   endtask

   task automatic collect(input int n);
      int       waited;
      int       k;
      int       b;
      bp_byte_t exp;
      for (k = 0; k < n; k++) begin
         waited = 0;
         while (rx_buf.size() <= rx_read) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
               abort_run("byte_valid_o never came for an expected byte");
            end
         end
         if (model_q.size() < BYTE_W) begin
            abort_run("a byte arrived that the model stream does not hold");
         end
         exp = '0;
         for (b = 0; b < BYTE_W; b++) begin
            exp = (exp << 1) | bp_byte_t'(model_q.pop_front());
         end
         check_byte(rx_buf[rx_read], exp);
         rx_read++;
      end
   endtask

   task automatic check_credits();
      int waited;
      waited = 0;
      while ((cmd_returned != cmd_sent) && (waited < TIMEOUT)) begin
         next_cycle();
         waited++;
      end
      check_count("cmd_credit_o pulses", cmd_returned, cmd_sent);
      // quiet window, nothing beyond the model stream may show up
      repeat (12) next_cycle();
      check_count("unexpected bytes", rx_buf.size() - rx_read, 0);
   endtask

   task automatic test_aligned();
      send_cmd(OP_PUSH, 8, 16'hA53C);
      send_cmd(OP_PUSH, 16, 16'h1234);
      send_cmd(OP_PUSH, 8, 16'h5AFF);
      send_cmd(OP_PUSH, 16, 16'hBEEF);
      collect(model_q.size() / BYTE_W);
      check_credits();
   endtask

   task automatic test_odd_widths();
      send_cmd(OP_PUSH, 3, 16'hA000);
      send_cmd(OP_PUSH, 5, 16'h7800);
      send_cmd(OP_PUSH, 7, 16'h1FFF);
      send_cmd(OP_PUSH, 13, 16'hC3A5);
      send_cmd(OP_PUSH, 4, 16'h9000);
      collect(model_q.size() / BYTE_W);
      check_credits();
   endtask

   task automatic test_flush();
      send_cmd(OP_PUSH, 3, 16'hB000);
      // pad is zero whatever the data field holds
      send_cmd(OP_FLUSH, 0, 16'hFFFF);
      send_cmd(OP_FLUSH, 0, 16'h0000);
      send_cmd(OP_PUSH, 0, 16'hFFFF);
      send_cmd(OP_PUSH, 5, 16'h6800);
      send_cmd(OP_PUSH, 0, 16'hFFFF);
      send_cmd(OP_PUSH, 3, 16'hE000);
      send_cmd(OP_FLUSH, 0, 16'h0000);
      collect(model_q.size() / BYTE_W);
      check_credits();
   endtask

   task automatic test_backpressure();
      int k;
      int waited;
      int base;
      base        = cmd_returned;
      credit_mode = CR_MANUAL;
      // 4 pushes drain into the fifo and output, 2 wait in the buffer
      for (k = 0; k < 6; k++) begin
         send_cmd(OP_PUSH, 16, DATA_W'(32'h1357 * (k + 1)));
      end
      waited = 0;
      while (rx_buf.size() - rx_read < `BP_OUT_CREDITS) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("bytes stopped before the output credits ran out");
         end
      end
      repeat (20) next_cycle();
      check_count("bytes without credit", rx_buf.size() - rx_read, `BP_OUT_CREDITS);
      check_count("cmd_credit_o pulses while stalled", cmd_returned - base, 4);
      give_credits(`BP_OUT_CREDITS);
      credit_mode = CR_AUTO;
      collect(model_q.size() / BYTE_W);
      check_credits();
   endtask

   task automatic test_random();
      int k;
      credit_mode = CR_RANDOM;
      for (k = 0; k < 200; k++) begin
         send_cmd(OP_PUSH, $urandom_range(16, 1), DATA_W'($urandom));
         if ($urandom_range(7, 0) == 0) begin
            send_cmd(OP_FLUSH, 0, DATA_W'($urandom));
         end
         repeat ($urandom_range(3, 0)) next_cycle();
      end
      send_cmd(OP_FLUSH, 0, '0);
      collect(model_q.size() / BYTE_W);
      credit_mode = CR_AUTO;
      check_credits();
   endtask

   initial begin
      void'($urandom(32'hdd11_676c));
      arst_n    = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = OP_PUSH;
      cmd_width = '0;
      cmd_data  = '0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;
      next_cycle();
      test_aligned();
      test_odd_widths();
      test_flush();
      test_backpressure();
      test_random();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bp_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module bp_asserts (
   input logic                   clk_i,
   input logic                   arst_n_i,
   input logic [`BP_LVL_W-1:0]   level_i,
   input logic [`BP_LVL_W-1:0]   wlevel_i,
   input logic                   write_i,
   input logic [`BP_WIDTH_W-1:0] wwidth_i,
   input logic                   read_i
);

   localparam int LVL_W = `BP_LVL_W;

   level_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      level_i <= LVL_W'(`BP_REG_W))
      else $error("fifo level %0d above register capacity", level_i);

   // decode must only write what fits
   write_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      write_i |-> (LVL_W'(wwidth_i) <= wlevel_i))
      else $error("write of %0d bits with %0d bits free", wwidth_i, wlevel_i);

   read_has_byte: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      read_i |-> (level_i >= LVL_W'(`BP_BYTE_W)))
      else $error("byte read with only %0d bits held", level_i);

endmodule

bind bp_bit_fifo bp_asserts u_asserts (
   .clk_i   (clk_i),
   .arst_n_i(arst_n_i),
   .level_i (level_q),
   .wlevel_i(wr_i.wlevel),
   .write_i (wr_i.write),
   .wwidth_i(wr_i.wwidth),
   .read_i  (read_i)
);

`default_nettype wire

// ==== bp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module bp_top import bp_pkg::*; (
   input  logic                   clk_i,
   input  logic                   arst_n_i,

   // command side
   input  logic                   cmd_valid_i,
   input  bp_op_e                 cmd_op_i,
   input  logic [`BP_WIDTH_W-1:0] cmd_width_i,
   input  logic [`BP_DATA_W-1:0]  cmd_data_i,
   output logic                   cmd_credit_o,

   // byte side
   output logic                   byte_valid_o,
   output bp_byte_t               byte_data_o,
   input  logic                   byte_credit_i
);

   bp_cmd_t              cmd;
   logic                 read;
   bp_byte_t             rdata;
   logic [`BP_LVL_W-1:0] rlevel;

   assign cmd = '{op: cmd_op_i, width: cmd_width_i, data: cmd_data_i};

   bp_wr_if u_wr_if ();

   bp_cmd_decode u_decode (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd),
      .cmd_credit_o(cmd_credit_o),
      .wr_o        (u_wr_if.decode)
   );

   bp_bit_fifo u_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .wr_i    (u_wr_if.fifo),
      .read_i  (read),
      .rdata_o (rdata),
      .rlevel_o(rlevel)
   );

   bp_byte_emit u_emit (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .rlevel_i     (rlevel),
      .rdata_i      (rdata),
      .read_o       (read),
      .byte_credit_i(byte_credit_i),
      .byte_valid_o (byte_valid_o),
      .byte_data_o  (byte_data_o)
   );

endmodule

`default_nettype wire

// ==== bp_byte_emit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module bp_byte_emit import bp_pkg::*; (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic [`BP_LVL_W-1:0] rlevel_i,
   input  bp_byte_t             rdata_i,
   output logic                 read_o,
   input  logic                 byte_credit_i,
   output logic                 byte_valid_o,
   output bp_byte_t             byte_data_o
);

   localparam int LVL_W = `BP_LVL_W;
   localparam int CRD_W = $clog2(`BP_OUT_CREDITS + 1);

   // free slots on the consumer side
   logic [CRD_W-1:0] credits_q;

   // a full byte and a slot to send it into
   assign read_o = (rlevel_i >= LVL_W'(`BP_BYTE_W)) && (credits_q != '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credits_q    <= CRD_W'(`BP_OUT_CREDITS);
         byte_valid_o <= 1'b0;
      end else begin
         byte_valid_o <= read_o;
         // send and return in one cycle cancel out
         case ({read_o, byte_credit_i})
            2'b10:   credits_q <= credits_q - 1'b1;
            2'b01:   credits_q <= credits_q + 1'b1;
            default: credits_q <= credits_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (read_o) begin
         byte_data_o <= rdata_i;
      end
   end

endmodule

`default_nettype wire

// ==== bp_bit_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module bp_bit_fifo import bp_pkg::*; (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   bp_wr_if.fifo                wr_i,
   input  logic                 read_i,
   output bp_byte_t             rdata_o,
   output logic [`BP_LVL_W-1:0] rlevel_o
);

   localparam int REG_W  = `BP_REG_W;
   localparam int DATA_W = `BP_DATA_W;
   localparam int BYTE_W = `BP_BYTE_W;
   localparam int LVL_W  = `BP_LVL_W;

   // occupied bits sit at the top of data_q
   logic [REG_W-1:0]  data_q;
   logic [REG_W-1:0]  data_shift;
   logic [REG_W-1:0]  data_nxt;
   logic [LVL_W-1:0]  level_q;
   logic [LVL_W-1:0]  level_shift;
   logic [LVL_W-1:0]  level_nxt;
   logic [DATA_W-1:0] wmask;
   logic [DATA_W-1:0] wbits;

   assign wr_i.wlevel = LVL_W'(REG_W) - level_q;
   assign rlevel_o    = level_q;
   assign rdata_o     = data_q[REG_W-1 -: BYTE_W];

   // keep only the top wwidth bits of the write data
   assign wmask = ~({DATA_W{1'b1}} >> wr_i.wwidth);
   assign wbits = wr_i.wdata & wmask;

   always_comb begin
      data_shift  = data_q;
      level_shift = level_q;
      if (read_i) begin
         data_shift  = data_q << BYTE_W;
         level_shift = level_q - LVL_W'(BYTE_W);
      end

      // new bits land right below what is left after the read
      data_nxt  = data_shift;
      level_nxt = level_shift;
      if (wr_i.write) begin
         data_nxt  = data_shift | ({wbits, {(REG_W - DATA_W){1'b0}}} >> level_shift);
         level_nxt = level_shift + LVL_W'(wr_i.wwidth);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_q  <= '0;
         level_q <= '0;
      end else begin
         data_q  <= data_nxt;
         level_q <= level_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== bp_cmd_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

module bp_cmd_decode import bp_pkg::*; (
   input  logic    clk_i,
   input  logic    arst_n_i,
   input  logic    cmd_valid_i,
   input  bp_cmd_t cmd_i,
   output logic    cmd_credit_o,
   bp_wr_if.decode wr_o
);

   localparam int DEPTH    = `BP_CMD_DEPTH;
   localparam int PTR_W    = $clog2(DEPTH);
   localparam int CNT_W    = $clog2(DEPTH + 1);
   localparam int WID_W    = `BP_WIDTH_W;
   localparam int LVL_W    = `BP_LVL_W;
   localparam int BYTE_LSB = $clog2(`BP_BYTE_W);

   bp_cmd_t          buf_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   bp_cmd_t          head;
   logic             head_valid;
   logic [WID_W-1:0] pad_width;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign head       = buf_q[rd_ptr_q];
   assign head_valid = (count_q != '0);

   // bits still missing to the next byte boundary
   assign pad_width = WID_W'(wr_o.wlevel[BYTE_LSB-1:0]);

   always_comb begin
      wr_o.write  = 1'b0;
      wr_o.wwidth = head.width;
      wr_o.wdata  = head.data;
      pop         = 1'b0;
      if (head_valid) begin
         case (head.op)
            OP_PUSH: begin
               // hold the push until all of it fits
               if (LVL_W'(head.width) <= wr_o.wlevel) begin
                  pop        = 1'b1;
                  wr_o.write = (head.width != '0);
               end
            end
            OP_FLUSH: begin
               // pad always fits, so a flush never waits
               pop         = 1'b1;
               wr_o.write  = (pad_width != '0);
               wr_o.wwidth = pad_width;
               wr_o.wdata  = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         count_q      <= '0;
         cmd_credit_o <= 1'b0;
      end else begin
         cmd_credit_o <= pop;
         if (cmd_valid_i) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(cmd_valid_i) - CNT_W'(pop);
      end
   end

   // upstream credits keep the buffer from overflowing
   always_ff @(posedge clk_i) begin
      if (cmd_valid_i) begin
         buf_q[wr_ptr_q] <= cmd_i;
      end
   end

endmodule

`default_nettype wire

// ==== bp_wr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_defines.svh"

interface bp_wr_if;

   logic                   write;
   logic [`BP_WIDTH_W-1:0] wwidth;
   logic [`BP_DATA_W-1:0]  wdata;
   // free bits left in the fifo register
   logic [`BP_LVL_W-1:0]   wlevel;

   modport decode (
      output write, wwidth, wdata,
      input  wlevel
   );

   modport fifo (
      input  write, wwidth, wdata,
      output wlevel
   );

endinterface

`default_nettype wire

// ==== bp_pkg.sv ====
`default_nettype none

`include "bp_defines.svh"

package bp_pkg;

   // command opcodes
   typedef enum logic {
      OP_PUSH  = 1'b0,
      OP_FLUSH = 1'b1
   } bp_op_e;

   // data is left aligned, the MSB goes out first
   typedef struct packed {
      bp_op_e                 op;
      logic [`BP_WIDTH_W-1:0] width;
      logic [`BP_DATA_W-1:0]  data;
   } bp_cmd_t;

   typedef logic [`BP_BYTE_W-1:0] bp_byte_t;

endpackage

`default_nettype wire

// ==== bp_defines.svh ====
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// widest single push, in bits
`define BP_DATA_W 16

// bit capacity of the packing register
`define BP_REG_W 32

// output byte and fifo read width
`define BP_BYTE_W 8

// command buffer entries, also the upstream credit count
`define BP_CMD_DEPTH 2

// byte credits held after reset
`define BP_OUT_CREDITS 4

// width field of a command, holds 0 to BP_DATA_W
`define BP_WIDTH_W ($clog2(`BP_DATA_W) + 1)

// level fields, hold 0 to BP_REG_W
`define BP_LVL_W ($clog2(`BP_REG_W) + 1)

`endif
